/* cube_render.f */
hw/cube_pkg.sv
hw/fb_write_if.sv
hw/line_queue.sv
hw/line_raster.sv
hw/framebuffer.sv
hw/scanout.sv
hw/cube_render.sv
tests/cube_render_sva.sv
tests/cube_render_tb.sv

/* hw/cube_pkg.sv */
/*
 * cube package: framebuffer geometry, display raster timing,
 * colour and line command types, and the 16-entry palette
 */
package cube_pkg;

    // framebuffer geometry
    localparam int FB_WIDTH  = 64;
    localparam int FB_HEIGHT = 48;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_CORDW  = 6;
    localparam int FB_ADDRW  = 12;

    // display raster, each framebuffer pixel shown as 2x2
    localparam int H_ACTIVE     = 128;
    localparam int V_ACTIVE     = 96;
    localparam int H_TOTAL      = 160;
    localparam int V_TOTAL      = 104;
    localparam int H_SYNC_START = 136;  // syncs active high, end exclusive
    localparam int H_SYNC_END   = 148;
    localparam int V_SYNC_START = 98;
    localparam int V_SYNC_END   = 100;
    localparam int SCREEN_CORDW = 8;

    typedef logic [3:0]          cidx_t;      // colour index
    typedef logic [23:0]         rgb_t;       // red in [23:16], blue in [7:0]
    typedef logic [FB_CORDW-1:0] fb_coord_t;

    typedef struct packed {
        fb_coord_t x0;
        fb_coord_t y0;
        fb_coord_t x1;
        fb_coord_t y1;
        cidx_t     colour;
    } line_cmd_t;

    // colour lookup table
    localparam rgb_t PALETTE [16] = '{
        24'h000000, 24'h1d2b53, 24'h7e2553, 24'h008751,
        24'hab5236, 24'h5f574f, 24'hc2c3c7, 24'hfff1e8,
        24'hff004d, 24'hffa300, 24'hffec27, 24'h00e436,
        24'h29adff, 24'h83769c, 24'hff77a8, 24'hffccaa
    };

endpackage

/* hw/cube_render.sv */
/*
 * line-drawing display pipeline top: command queue, rasterizer,
 * framebuffer and scanout to 24-bit RGB with syncs
 */
`timescale 1ns/1ps

module cube_render #(
    parameter int LINE_Q_DEPTH = 4
) (
    input  logic                clk_pix,
    input  logic                arst_n,
    input  logic                cmd_valid,
    input  cube_pkg::fb_coord_t cmd_x0,
    input  cube_pkg::fb_coord_t cmd_y0,
    input  cube_pkg::fb_coord_t cmd_x1,
    input  cube_pkg::fb_coord_t cmd_y1,
    input  cube_pkg::cidx_t     cmd_colour,
    output logic                draw_busy,
    output logic                de,
    output logic                hsync,
    output logic                vsync,
    output logic                frame_start,
    output logic [7:0]          red,
    output logic [7:0]          green,
    output logic [7:0]          blue
);
    import cube_pkg::*;

    line_cmd_t           cmd_in;
    line_cmd_t           cmd_head;
    logic                issue;
    logic                pending;
    logic                raster_busy;
    logic [FB_ADDRW-1:0] rd_addr;
    cidx_t               rd_cidx;
    rgb_t                rgb;

    fb_write_if i_fb_wr ();

    assign cmd_in = '{x0: cmd_x0, y0: cmd_y0, x1: cmd_x1, y1: cmd_y1, colour: cmd_colour};

    line_queue #(
        .LINE_Q_DEPTH(LINE_Q_DEPTH)
    ) i_line_queue (
        .clk_pix     (clk_pix),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd_in      (cmd_in),
        .raster_busy (raster_busy),
        .issue       (issue),
        .cmd_out     (cmd_head),
        .pending     (pending)
    );

    line_raster i_line_raster (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .issue   (issue),
        .cmd     (cmd_head),
        .busy    (raster_busy),
        .fb      (i_fb_wr.raster)
    );

    framebuffer i_framebuffer (
        .clk_pix (clk_pix),
        .fb      (i_fb_wr.store),
        .rd_addr (rd_addr),
        .rd_cidx (rd_cidx)
    );

    scanout i_scanout (
        .clk_pix     (clk_pix),
        .arst_n      (arst_n),
        .rd_addr     (rd_addr),
        .rd_cidx     (rd_cidx),
        .de          (de),
        .hsync       (hsync),
        .vsync       (vsync),
        .frame_start (frame_start),
        .rgb         (rgb)
    );

    assign draw_busy          = pending || raster_busy;  // queued or still drawing
    assign {red, green, blue} = rgb;

endmodule

/* hw/fb_write_if.sv */
/*
 * framebuffer write port, rasterizer to framebuffer
 * one pixel written in every cycle with we high
 */
`timescale 1ns/1ps

interface fb_write_if;
    import cube_pkg::*;

    logic      we;
    fb_coord_t x;
    fb_coord_t y;
    cidx_t     cidx;

    modport raster (
        output we, x, y, cidx
    );

    modport store (
        input  we, x, y, cidx
    );

endinterface

/* hw/framebuffer.sv */
/*
 * indexed-colour framebuffer, simple dual-port with a registered read
 * write side addressed by pixel coordinates
 */
`timescale 1ns/1ps

module framebuffer (
    input  logic                          clk_pix,
    fb_write_if.store                     fb,
    input  logic [cube_pkg::FB_ADDRW-1:0] rd_addr,
    output cube_pkg::cidx_t               rd_cidx
);
    import cube_pkg::*;

    cidx_t               mem [FB_PIXELS];
    logic [FB_ADDRW-1:0] wr_addr;

    // power-up contents, black everywhere
    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    // row-major, y * width + x
    assign wr_addr = FB_ADDRW'(fb.y) * FB_ADDRW'(FB_WIDTH) + FB_ADDRW'(fb.x);

    always_ff @(posedge clk_pix) begin
        if (fb.we) begin
            mem[wr_addr] <= fb.cidx;
        end
    end

    // read before write on a shared address
    always_ff @(posedge clk_pix) begin
        rd_cidx <= mem[rd_addr];
    end

endmodule

/* hw/line_queue.sv */
/*
 * line command queue, circular FIFO that buffers strobed commands
 * and hands the head to the rasterizer whenever it is idle
 */
`timescale 1ns/1ps

module line_queue #(
    parameter int LINE_Q_DEPTH = 4
) (
    input  logic                clk_pix,
    input  logic                arst_n,
    input  logic                cmd_valid,
    input  cube_pkg::line_cmd_t cmd_in,
    input  logic                raster_busy,
    output logic                issue,
    output cube_pkg::line_cmd_t cmd_out,
    output logic                pending
);
    import cube_pkg::*;

    localparam int PTR_W = (LINE_Q_DEPTH > 1) ? $clog2(LINE_Q_DEPTH) : 1;
    localparam int CNT_W = $clog2(LINE_Q_DEPTH + 1);

    line_cmd_t        mem [LINE_Q_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;

    // wraps at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(LINE_Q_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(LINE_Q_DEPTH));
    assign push    = cmd_valid && !full;            // a command into a full queue is lost
    assign issue   = (count != '0) && !raster_busy;
    assign cmd_out = mem[rd_ptr];

    // head stays counted through its issue cycle
    assign pending = (count != '0);

    always_ff @(posedge clk_pix) begin
        if (push) begin
            mem[wr_ptr] <= cmd_in;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_inc(rd_ptr);  // pop the head
            end
            case ({push, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

/* hw/line_raster.sv */
/*
 * Bresenham line rasterizer, one framebuffer write per cycle
 * from start point to end point inclusive, any octant
 */
`timescale 1ns/1ps

module line_raster (
    input  logic                clk_pix,
    input  logic                arst_n,
    input  logic                issue,
    input  cube_pkg::line_cmd_t cmd,
    output logic                busy,
    fb_write_if.raster          fb
);
    import cube_pkg::*;

    localparam int ERRW = FB_CORDW + 3;  // room for twice the error term

    fb_coord_t              x;
    fb_coord_t              y;
    fb_coord_t              x_end;
    fb_coord_t              y_end;
    cidx_t                  colour;
    logic signed [ERRW-1:0] dx;
    logic signed [ERRW-1:0] dy;         // held negative
    logic signed [ERRW-1:0] err;
    logic signed [ERRW-1:0] e2;
    logic                   x_neg;      // step directions
    logic                   y_neg;
    logic                   at_end;
    logic                   step_x;
    logic                   step_y;

    function automatic logic signed [ERRW-1:0] abs_diff(input fb_coord_t a, input fb_coord_t b);
        return (a > b) ? ERRW'(a - b) : ERRW'(b - a);
    endfunction

    assign at_end = (x == x_end) && (y == y_end);
    assign e2     = err <<< 1;
    assign step_x = (e2 >= dy);
    assign step_y = (e2 <= dx);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (issue) begin
            busy <= 1'b1;
        end else if (busy && at_end) begin
            busy <= 1'b0;  // end point written this cycle
        end
    end

    always_ff @(posedge clk_pix) begin
        if (issue) begin
            x      <= cmd.x0;
            y      <= cmd.y0;
            x_end  <= cmd.x1;
            y_end  <= cmd.y1;
            colour <= cmd.colour;
            x_neg  <= (cmd.x1 < cmd.x0);
            y_neg  <= (cmd.y1 < cmd.y0);
            dx     <= abs_diff(cmd.x0, cmd.x1);
            dy     <= -abs_diff(cmd.y0, cmd.y1);
            err    <= abs_diff(cmd.x0, cmd.x1) - abs_diff(cmd.y0, cmd.y1);
        end else if (busy && !at_end) begin
            if (step_x) begin
                x <= x_neg ? x - 1'b1 : x + 1'b1;
            end
            if (step_y) begin
                y <= y_neg ? y - 1'b1 : y + 1'b1;
            end
            // both tests use the error from before the step
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
        end
    end

    assign fb.we   = busy;
    assign fb.x    = x;
    assign fb.y    = y;
    assign fb.cidx = colour;

endmodule

/* hw/scanout.sv */
/*
 * scanout: raster counters, 2x doubled framebuffer read and palette lookup,
 * with de, syncs and frame start delayed to line up with the colour
 */
`timescale 1ns/1ps

module scanout (
    input  logic                          clk_pix,
    input  logic                          arst_n,
    output logic [cube_pkg::FB_ADDRW-1:0] rd_addr,
    input  cube_pkg::cidx_t               rd_cidx,
    output logic                          de,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          frame_start,
    output cube_pkg::rgb_t                rgb
);
    import cube_pkg::*;

    logic [SCREEN_CORDW-1:0] sx;
    logic [SCREEN_CORDW-1:0] sy;
    logic                    de_0;     // at counter position
    logic                    hsync_0;
    logic                    vsync_0;
    logic                    start_0;
    logic                    de_1;     // aligned with rd_cidx
    logic                    hsync_1;
    logic                    vsync_1;
    logic                    start_1;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == SCREEN_CORDW'(H_TOTAL - 1)) begin
            sx <= '0;
            sy <= (sy == SCREEN_CORDW'(V_TOTAL - 1)) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    assign de_0    = (sx < SCREEN_CORDW'(H_ACTIVE)) && (sy < SCREEN_CORDW'(V_ACTIVE));
    assign hsync_0 = (sx >= SCREEN_CORDW'(H_SYNC_START)) && (sx < SCREEN_CORDW'(H_SYNC_END));
    assign vsync_0 = (sy >= SCREEN_CORDW'(V_SYNC_START)) && (sy < SCREEN_CORDW'(V_SYNC_END));
    assign start_0 = (sx == '0) && (sy == '0);

    // halve both coordinates for the doubled pixel, blanking reads address zero
    assign rd_addr = de_0 ? FB_ADDRW'(sy >> 1) * FB_ADDRW'(FB_WIDTH) + FB_ADDRW'(sx >> 1)
                          : '0;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            de_1        <= 1'b0;
            hsync_1     <= 1'b0;
            vsync_1     <= 1'b0;
            start_1     <= 1'b0;
            de          <= 1'b0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            frame_start <= 1'b0;
            rgb         <= '0;
        end else begin
            de_1        <= de_0;   // stage 1, memory read
            hsync_1     <= hsync_0;
            vsync_1     <= vsync_0;
            start_1     <= start_0;
            de          <= de_1;   // stage 2, palette
            hsync       <= hsync_1;
            vsync       <= vsync_1;
            frame_start <= start_1;
            rgb         <= de_1 ? PALETTE[rd_cidx] : '0;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the cube_render testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module cube_render_tb \
    -f cube_render.f -o cube_render_sim
./obj_dir/cube_render_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* tests/cube_render_sva.sv */
/*
 * bound checks on queue overflow, framebuffer writes past the last row
 * and frame start alignment with data enable
 */
`timescale 1ns/1ps

module cube_render_sva (
    input logic                clk_pix,
    input logic                arst_n,
    input logic                cmd_valid,
    input logic                q_full,
    input logic                we,
    input cube_pkg::fb_coord_t wr_y,
    input logic                de,
    input logic                frame_start
);
    import cube_pkg::*;

    // a strobe into a full queue is dropped
    queue_no_overflow: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !(cmd_valid && q_full))
        else $error("line command strobed while the queue is full");

    // rows past the bottom land beyond the memory
    write_in_frame: assert property (@(posedge clk_pix) disable iff (!arst_n)
        we |-> (wr_y < FB_CORDW'(FB_HEIGHT)))
        else $error("framebuffer write below the last row");

    // frame start lands on the first de cycle of the frame
    start_on_first_de: assert property (@(posedge clk_pix) disable iff (!arst_n)
        frame_start |-> $rose(de))
        else $error("frame start not on the first data enable cycle");

endmodule

/* tests/cube_render_tb.sv */
/*
 * cube_render testbench that replays line commands from the vectors file
 * and checks every scanned-out frame against a shadow framebuffer
 */
`timescale 1ns/1ps

module cube_render_tb;
    import cube_pkg::*;

    localparam int LINE_Q_DEPTH = 4;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int N_TESTS      = 4;
    localparam int CYCLE_LIMIT  = N_TESTS * 3 * FRAME_CYCLES + 2000;  // three frames a test

    logic       clk_pix;
    logic       arst_n;
    logic       cmd_valid;
    fb_coord_t  cmd_x0;
    fb_coord_t  cmd_y0;
    fb_coord_t  cmd_x1;
    fb_coord_t  cmd_y1;
    cidx_t      cmd_colour;
    logic       draw_busy;
    logic       de;
    logic       hsync;
    logic       vsync;
    logic       frame_start;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    cidx_t shadow [FB_PIXELS];  // expected framebuffer contents
    int    errors = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    test_start_errors = 0;
    int    cycles = 0;

    cube_render #(
        .LINE_Q_DEPTH(LINE_Q_DEPTH)
    ) i_cube_render (
        .clk_pix     (clk_pix),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd_x0      (cmd_x0),
        .cmd_y0      (cmd_y0),
        .cmd_x1      (cmd_x1),
        .cmd_y1      (cmd_y1),
        .cmd_colour  (cmd_colour),
        .draw_busy   (draw_busy),
        .de          (de),
        .hsync       (hsync),
        .vsync       (vsync),
        .frame_start (frame_start),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

    bind cube_render cube_render_sva i_cube_render_sva (
        .clk_pix     (clk_pix),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .q_full      (i_line_queue.full),
        .we          (i_fb_wr.we),
        .wr_y        (i_fb_wr.y),
        .de          (de),
        .frame_start (frame_start)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout, run still going after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_rgb(input rgb_t got, input rgb_t want, input int sx, input int sy);
        if (got !== want) begin
            errors++;
            $display("MISMATCH rgb at (%0d,%0d): got %h expected %h", sx, sy, got, want);
        end
    endtask

    task automatic check_sync(input logic [2:0] got, input logic [2:0] want,
                              input int sx, input int sy);
        if (got !== want) begin
            errors++;
            $display("MISMATCH {de,hsync,vsync} at (%0d,%0d): got %h expected %h",
                     sx, sy, got, want);
        end
    endtask

    // reference Bresenham with both endpoints drawn
    task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                              input cidx_t c);
        int dx;
        int dy;
        int step_x;
        int step_y;
        int err;
        int e2;
        int x;
        int y;
        dx     = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy     = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
        step_x = (x0 < x1) ? 1 : -1;
        step_y = (y0 < y1) ? 1 : -1;
        err    = dx + dy;
        x      = x0;
        y      = y0;
        forever begin
            shadow[y * FB_WIDTH + x] = c;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += step_x;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += step_y;
            end
        end
    endtask

    task automatic send_cmd(input line_cmd_t c);
        @(posedge clk_pix);
        cmd_valid  <= 1'b1;
        cmd_x0     <= c.x0;
        cmd_y0     <= c.y0;
        cmd_x1     <= c.x1;
        cmd_y1     <= c.y1;
        cmd_colour <= c.colour;
        @(posedge clk_pix);
        cmd_valid <= 1'b0;
        @(posedge clk_pix);  // two idle cycles before the next strobe
    endtask

    task automatic wait_idle();
        @(negedge clk_pix);
        while (draw_busy) @(negedge clk_pix);
    endtask

    // pixels and timing of one whole frame from frame_start
    task automatic check_frame();
        int   sx;
        int   sy;
        int   de_cnt;
        int   hs_cnt;
        int   vs_cnt;
        logic hs_prev;
        logic vs_prev;
        logic want_de;
        rgb_t want;
        de_cnt = 0;
        hs_cnt = 0;
        vs_cnt = 0;
        while (!frame_start) @(negedge clk_pix);
        hs_prev = hsync;
        vs_prev = vsync;
        for (int k = 0; k < FRAME_CYCLES; k++) begin
            sx      = k % H_TOTAL;
            sy      = k / H_TOTAL;
            want_de = (sx < H_ACTIVE) && (sy < V_ACTIVE);
            check_sync({de, hsync, vsync},
                       {want_de, sx >= H_SYNC_START && sx < H_SYNC_END,
                        sy >= V_SYNC_START && sy < V_SYNC_END}, sx, sy);
            want = want_de ? PALETTE[shadow[(sy / 2) * FB_WIDTH + sx / 2]] : '0;
            check_rgb({red, green, blue}, want, sx, sy);
            if (frame_start != (k == 0)) begin
                errors++;
                $display("frame_start at the wrong position (%0d,%0d)", sx, sy);
            end
            if (de) de_cnt++;
            if (hsync && !hs_prev) hs_cnt++;
            if (vsync && !vs_prev) vs_cnt++;
            hs_prev = hsync;
            vs_prev = vsync;
            @(negedge clk_pix);
        end
        if (!frame_start) begin
            errors++;
            $display("no frame_start after %0d cycles, frame length is wrong", FRAME_CYCLES);
        end
        if (de_cnt != H_ACTIVE * V_ACTIVE || hs_cnt != V_TOTAL || vs_cnt != 1) begin
            errors++;
            $display("wrong frame timing with %0d de cycles, %0d hsync and %0d vsync pulses",
                     de_cnt, hs_cnt, vs_cnt);
        end
    endtask

    task automatic finish_test(input string name);
        wait_idle();
        repeat (4) @(negedge clk_pix);  // frame read starts after the last write
        check_frame();
        if (errors == test_start_errors) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail, %0d errors", name, errors - test_start_errors);
        end
    endtask

    initial begin
        string     line;
        string     name;
        string     cur_name;
        int        fd;
        int        f [5];
        int        outstanding;
        logic      in_test;
        line_cmd_t cmd;
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_x0      = '0;
        cmd_y0      = '0;
        cmd_x1      = '0;
        cmd_y1      = '0;
        cmd_colour  = '0;
        outstanding = 0;
        in_test     = 1'b0;
        for (int i = 0; i < FB_PIXELS; i++) shadow[i] = '0;
        repeat (8) @(posedge clk_pix);
        @(negedge clk_pix);
        if (draw_busy || de || hsync || vsync || frame_start) begin
            errors++;
            $display("outputs not low during reset");
        end
        @(posedge clk_pix);
        arst_n <= 1'b1;
        fd = $fopen("tests/cube_render_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open tests/cube_render_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "T %s", name) == 1) begin
                    if (in_test) finish_test(cur_name);
                    cur_name          = name;
                    in_test           = 1'b1;
                    outstanding       = 0;
                    test_start_errors = errors;
                end else if ($sscanf(line, "L %d %d %d %d %d",
                                     f[0], f[1], f[2], f[3], f[4]) == 5) begin
                    cmd = '{x0: fb_coord_t'(f[0]), y0: fb_coord_t'(f[1]),
                            x1: fb_coord_t'(f[2]), y1: fb_coord_t'(f[3]),
                            colour: cidx_t'(f[4])};
                    model_line(f[0], f[1], f[2], f[3], cidx_t'(f[4]));
                    send_cmd(cmd);
                    outstanding++;
                    if (outstanding == LINE_Q_DEPTH) begin
                        wait_idle();  // queue could be full
                        outstanding = 0;
                    end
                end
            end
            if (in_test) finish_test(cur_name);
            $fclose(fd);
        end
        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tests/cube_render_vectors.txt */
# T <name> opens a test group; L x0 y0 x1 y1 colour is one line command, all decimal
T blank_frame
T straight_lines
L 4 2 40 2 7
L 50 6 10 6 8
L 2 4 2 40 12
L 60 44 60 10 11
T cube
L 20 14 44 14 7
L 44 14 44 38 7
L 44 38 20 38 7
L 20 38 20 14 7
L 20 14 30 6 6
L 44 14 54 6 6
L 44 38 54 30 6
L 30 6 54 6 12
L 54 6 54 30 12
T diagonals
L 32 24 50 30 9
L 32 24 38 44 10
L 32 24 26 46 11
L 32 24 8 30 14
L 32 24 10 18 15
L 32 24 28 2 3
L 32 24 36 1 4
L 32 24 63 20 5
L 0 0 0 0 8
L 63 47 63 47 9
L 16 24 48 24 2
